// ==== filelist.f ====
logic/hdd_pkg.sv
logic/hdd_bus_decode.sv
logic/hdd_command_engine.sv
logic/hdd_sector_buffer.sv
logic/hdd_read_mux.sv
logic/hdd_controller.sv
dv/hdd_properties.sv
dv/hdd_tb.sv

// ==== Makefile ====
# Verilator flow for the block-device controller testbench
TOP := hdd_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --timescale 1ns/1ps -f filelist.f --top-module $(TOP)

obj_dir/V$(TOP): filelist.f logic/*.sv dv/*.sv
	verilator --binary --timing --assert --timescale 1ns/1ps -f filelist.f \
		--top-module $(TOP) -Mdir obj_dir

sim: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) +verilator+error+limit+100 > sim.log 2>&1 || true
	cat sim.log
	grep -q '^STATUS: PASS$$' sim.log

clean:
	rm -rf obj_dir sim.log

// ==== dv/hdd_tb.sv ====
/*
 * Directed testbench for the block-device controller
 * Unit 0 is mounted and unit 1 is not, protect is raised only by the error test
 * The host model serves one request at a time in four-phase order
 */
module hdd_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int clk_period    = 8;
    // One bus access is 4 cycles of select plus 2 idle
    localparam int access_cycles = 6;
    // Two full sector streams dominate, plus a few hundred other accesses
    localparam int test_cycles   = 2 * 512 * (access_cycles + 1) + 200 * access_cycles;
    localparam int watchdog_ns   = 3 * test_cycles * clk_period;
    localparam int req_timeout   = 64;

    logic               CLK_14M;
    logic               RESET;
    logic               device_select;
    logic [3:0]         addr;
    logic               rd;
    logic [7:0]         data_in;
    logic [7:0]         data_out;
    logic [1:0]         mounted;
    logic [1:0]         protect;
    logic               host_req;
    hdd_pkg::host_req_t host_cmd;
    logic               host_ack;
    logic [8:0]         ram_addr;
    logic [7:0]         ram_di;
    logic               ram_we;
    logic [7:0]         ram_do;

    int         errors;
    int         assert_fails;
    // Bytes the CPU streamed in, and what the host read back
    logic [7:0] wr_bytes [512];
    logic [7:0] host_rb [512];

    hdd_controller #(
        .unit_count (2)
    ) u_hdd_controller (
        .CLK_14M       (CLK_14M),
        .RESET         (RESET),
        .device_select (device_select),
        .addr          (addr),
        .rd            (rd),
        .data_in       (data_in),
        .data_out      (data_out),
        .mounted       (mounted),
        .protect       (protect),
        .host_req      (host_req),
        .host_cmd      (host_cmd),
        .host_ack      (host_ack),
        .ram_addr      (ram_addr),
        .ram_di        (ram_di),
        .ram_we        (ram_we),
        .ram_do        (ram_do)
    );

    initial begin
        CLK_14M = 1'b0;
        forever #(clk_period / 2) CLK_14M = ~CLK_14M;
    end

    // ------------------------------------------------------------------------
    // Compare tasks
    // ------------------------------------------------------------------------
    task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %s got 0x%02h expected 0x%02h", name, got, exp);
        end
    endtask

    task automatic check_status(input string name, input logic [7:0] got,
                                input logic [7:0] exp);
        if (got !== exp) begin
            errors++;
            $display("[FAIL] status %s got 0x%02h expected 0x%02h", name, got, exp);
        end
    endtask

    task automatic check_host_req(input hdd_pkg::host_req_t got, input hdd_pkg::host_req_t exp);
        if (got !== exp) begin
            errors++;
            $display("[FAIL] host_cmd got 0x%05h expected 0x%05h", got, exp);
        end
    endtask

    task automatic check_req_level(input logic level, input string what);
        if (host_req !== level) begin
            errors++;
            $display("[FAIL] host_req after %s got 0x%0h expected 0x%0h", what, host_req, level);
        end
    endtask

    // ------------------------------------------------------------------------
    // Bus and host models, every task starts and ends on a falling edge
    // ------------------------------------------------------------------------
    task automatic bus_cycle(input logic [3:0] a, input logic is_rd, input logic [7:0] wd,
                             output logic [7:0] rdata);
        device_select = 1'b1;
        addr          = a;
        rd            = is_rd;
        data_in       = wd;
        repeat (4) @(negedge CLK_14M);
        // Read data has been stable since the second cycle
        rdata         = data_out;
        device_select = 1'b0;
        rd            = 1'b0;
        repeat (2) @(negedge CLK_14M);
    endtask

    task automatic bus_write(input logic [3:0] a, input logic [7:0] wd);
        logic [7:0] rdata;
        bus_cycle(a, 1'b0, wd, rdata);
        check_byte("data_out on write", rdata, 8'hFF);
    endtask

    task automatic bus_read(input logic [3:0] a, output logic [7:0] rdata);
        bus_cycle(a, 1'b1, 8'h00, rdata);
    endtask

    task automatic serve_host();
        int                 waited;
        hdd_pkg::host_req_t req;
        waited = 0;
        while (!host_req && waited < req_timeout) begin
            @(negedge CLK_14M);
            waited++;
        end
        if (!host_req) begin
            errors++;
            $display("Host model saw no request within %0d cycles", req_timeout);
        end else begin
            req = host_cmd;
            if (req.op == hdd_pkg::op_read_block) begin
                // Block fill pattern is the low block byte XOR the offset
                for (int i = 0; i < 512; i++) begin
                    ram_addr = 9'(i);
                    ram_di   = req.block[7:0] ^ 8'(i);
                    ram_we   = 1'b1;
                    @(negedge CLK_14M);
                end
                ram_we = 1'b0;
            end else begin
                // DMA read data shows up two cycles after the address
                for (int k = 0; k < 514; k++) begin
                    if (k >= 2) begin
                        host_rb[9'(k - 2)] = ram_do;
                    end
                    if (k < 512) begin
                        ram_addr = 9'(k);
                    end
                    @(negedge CLK_14M);
                end
            end
            repeat ($urandom_range(0, 3)) @(negedge CLK_14M);
            host_ack = 1'b1;
            waited   = 0;
            while (host_req && waited < req_timeout) begin
                @(negedge CLK_14M);
                waited++;
            end
            if (host_req) begin
                errors++;
                $display("host_req stayed high %0d cycles after host_ack", req_timeout);
            end
            repeat ($urandom_range(0, 3)) @(negedge CLK_14M);
            host_ack = 1'b0;
        end
    endtask

    // ------------------------------------------------------------------------
    // Directed tests
    // ------------------------------------------------------------------------
    task automatic test_registers();
        logic [7:0] vals [8];
        logic [7:0] rdata;
        bus_read(4'h1, rdata);
        check_status("after reset", rdata, hdd_pkg::status_ok);
        check_byte("data_out idle", data_out, 8'hFF);
        for (int a = 3; a <= 7; a++) begin
            vals[3'(a)] = 8'($urandom());
            bus_write(4'(a), vals[3'(a)]);
        end
        for (int a = 3; a <= 7; a++) begin
            bus_read(4'(a), rdata);
            check_byte($sformatf("data_out offset %0d", a), rdata, vals[3'(a)]);
        end
        check_byte("data_out idle", data_out, 8'hFF);
    endtask

    task automatic test_status_cmd();
        logic [7:0] rdata;
        // Unit select is bit 7 of the unit register
        bus_write(4'h3, 8'h00);
        bus_write(4'h2, hdd_pkg::cmd_status);
        bus_read(4'h0, rdata);
        check_status("STATUS on mounted unit", rdata, hdd_pkg::status_ok);
        bus_write(4'h3, 8'h80);
        bus_read(4'h0, rdata);
        check_status("STATUS on unmounted unit", rdata, hdd_pkg::status_error);
    endtask

    task automatic test_read();
        logic [7:0]         rdata;
        logic [7:0]         blk_lo;
        logic [7:0]         blk_hi;
        hdd_pkg::host_req_t exp;
        blk_lo = 8'($urandom());
        blk_hi = 8'($urandom());
        bus_write(4'h3, 8'h00);
        bus_write(4'h6, blk_lo);
        bus_write(4'h7, blk_hi);
        bus_write(4'h2, hdd_pkg::cmd_read);
        bus_read(4'h1, rdata);
        check_status("after READ command", rdata, hdd_pkg::status_busy);
        bus_read(4'h0, rdata);
        check_status("execute READ", rdata, hdd_pkg::status_busy);
        exp.op    = hdd_pkg::op_read_block;
        exp.unit  = 1'b0;
        exp.block = {blk_hi, blk_lo};
        check_req_level(1'b1, "execute READ");
        check_host_req(host_cmd, exp);
        serve_host();
        // Byte 0 comes from the prefetch, the rest from the pointer
        for (int i = 0; i < 512; i++) begin
            bus_read(4'h8, rdata);
            check_byte($sformatf("data_out next byte %0d", i), rdata, blk_lo ^ 8'(i));
        end
        bus_read(4'h1, rdata);
        check_status("after READ stream", rdata, hdd_pkg::status_ok);
    endtask

    task automatic test_write();
        logic [7:0]         rdata;
        hdd_pkg::host_req_t exp;
        bus_write(4'h3, 8'h00);
        bus_write(4'h6, 8'h5A);
        bus_write(4'h7, 8'h01);
        bus_write(4'h2, hdd_pkg::cmd_write);
        bus_read(4'h1, rdata);
        check_status("after WRITE command", rdata, hdd_pkg::status_busy);
        for (int i = 0; i < 512; i++) begin
            wr_bytes[9'(i)] = 8'($urandom());
            bus_write(4'h8, wr_bytes[9'(i)]);
        end
        bus_read(4'h0, rdata);
        check_status("execute WRITE", rdata, hdd_pkg::status_busy);
        exp.op    = hdd_pkg::op_write_block;
        exp.unit  = 1'b0;
        exp.block = 16'h015A;
        check_req_level(1'b1, "execute WRITE");
        check_host_req(host_cmd, exp);
        serve_host();
        for (int i = 0; i < 512; i++) begin
            check_byte($sformatf("ram_do byte %0d", i), host_rb[9'(i)], wr_bytes[9'(i)]);
        end
        bus_read(4'h1, rdata);
        check_status("after WRITE handshake", rdata, hdd_pkg::status_ok);
    endtask

    task automatic test_errors();
        logic [7:0] rdata;
        // Protected unit 0 rejects WRITE
        protect = 2'b01;
        bus_write(4'h3, 8'h00);
        bus_write(4'h2, hdd_pkg::cmd_write);
        bus_read(4'h0, rdata);
        check_byte("data_out execute WRITE protected", rdata, hdd_pkg::status_protect);
        check_req_level(1'b0, "WRITE to a protected unit");
        bus_read(4'h1, rdata);
        check_status("after protected WRITE", rdata, hdd_pkg::status_error);
        // Unmounted unit 1 rejects READ
        protect = 2'b00;
        bus_write(4'h3, 8'h80);
        bus_write(4'h2, hdd_pkg::cmd_read);
        bus_read(4'h0, rdata);
        check_status("execute READ unmounted", rdata, hdd_pkg::status_error);
        check_req_level(1'b0, "READ of an unmounted unit");
        bus_read(4'h1, rdata);
        check_status("after unmounted READ", rdata, hdd_pkg::status_error);
    endtask

    // ------------------------------------------------------------------------
    // Sequence, watchdog and verdict
    // ------------------------------------------------------------------------
    initial begin
        void'($urandom(91668));
        errors        = 0;
        RESET         = 1'b1;
        device_select = 1'b0;
        addr          = 4'h0;
        rd            = 1'b0;
        data_in       = 8'h00;
        mounted       = 2'b01;
        protect       = 2'b00;
        host_ack      = 1'b0;
        ram_addr      = 9'h000;
        ram_di        = 8'h00;
        ram_we        = 1'b0;
        repeat (8) @(posedge CLK_14M);
        @(negedge CLK_14M);
        RESET = 1'b0;
        repeat (2) @(negedge CLK_14M);
        test_registers();
        test_status_cmd();
        test_read();
        test_write();
        test_errors();
        repeat (4) @(negedge CLK_14M);
        assert_fails = u_hdd_controller.u_hdd_command_engine.u_hdd_properties.fail_count;
        $display("Checks done with %0d check errors and %0d assertion failures",
                 errors, assert_fails);
        if (errors == 0 && assert_fails == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    initial begin
        #(watchdog_ns);
        $display("Watchdog expired after %0d ns before the tests finished", watchdog_ns);
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

// ==== dv/hdd_properties.sv ====
/*
 * Handshake and reset checks on the command engine
 * Bound into every hdd_command_engine instance
 */
module hdd_properties (
    input logic               CLK_14M,
    input logic               RESET,
    input logic               host_req,
    input logic               host_ack,
    input hdd_pkg::host_req_t host_cmd
);
    timeunit 1ns;
    timeprecision 1ps;

    // Failed assertions, read by the testbench at the end
    int fail_count = 0;

    // Request holds until the host acknowledges
    req_held_until_ack: assert property (
        @(posedge CLK_14M) disable iff (RESET)
        host_req && !host_ack |=> host_req
    ) else begin
        $error("host_req dropped before host_ack");
        fail_count++;
    end

    // Payload frozen for the whole request
    cmd_stable_while_req: assert property (
        @(posedge CLK_14M) disable iff (RESET)
        host_req |=> !host_req || $stable(host_cmd)
    ) else begin
        $error("host_cmd changed while host_req was high");
        fail_count++;
    end

    req_low_in_reset: assert property (
        @(posedge CLK_14M)
        RESET |=> !host_req
    ) else begin
        $error("host_req high after a reset cycle");
        fail_count++;
    end

endmodule

bind hdd_command_engine hdd_properties u_hdd_properties (
    .CLK_14M  (CLK_14M),
    .RESET    (RESET),
    .host_req (host_req),
    .host_ack (host_ack),
    .host_cmd (host_cmd)
);

// ==== logic/hdd_controller.sv ====
/*
 * ProDOS block-device controller for an Apple II slot
 * Slot ROM sits outside, this covers the device window registers only
 * Host side must follow the four-phase req/ack order
 */
module hdd_controller #(
    parameter int unit_count = 2
) (
    input  logic                              CLK_14M,
    input  logic                              RESET,
    // CPU bus
    input  logic                              device_select,
    input  logic [3:0]                        addr,
    input  logic                              rd,
    input  logic [7:0]                        data_in,
    output logic [7:0]                        data_out,
    // Drive state from the host
    input  logic [unit_count-1:0]             mounted,
    input  logic [unit_count-1:0]             protect,
    // Block transfer handshake
    output logic                              host_req,
    output hdd_pkg::host_req_t                host_cmd,
    input  logic                              host_ack,
    // Host DMA port into the sector buffer
    input  logic [hdd_pkg::sector_addr_w-1:0] ram_addr,
    input  logic [7:0]                        ram_di,
    input  logic                              ram_we,
    output logic [7:0]                        ram_do
);

    hdd_pkg::bus_access_t access;
    hdd_pkg::buf_ctl_t    buf_ctl;
    hdd_pkg::hdd_regs_t   regs;
    logic [7:0]           status;
    logic [7:0]           exec_data;
    logic                 exec_valid;
    logic [7:0]           next_data;

    // ------------------------------------------------------------------------
    // Decode, execute, buffer and result stages
    // ------------------------------------------------------------------------
    hdd_bus_decode u_hdd_bus_decode (
        .CLK_14M       (CLK_14M),
        .RESET         (RESET),
        .device_select (device_select),
        .addr          (addr),
        .rd            (rd),
        .data_in       (data_in),
        .access        (access)
    );

    hdd_command_engine #(
        .unit_count (unit_count)
    ) u_hdd_command_engine (
        .CLK_14M    (CLK_14M),
        .RESET      (RESET),
        .access     (access),
        .mounted    (mounted),
        .protect    (protect),
        .host_ack   (host_ack),
        .host_req   (host_req),
        .host_cmd   (host_cmd),
        .buf_ctl    (buf_ctl),
        .regs       (regs),
        .status     (status),
        .exec_data  (exec_data),
        .exec_valid (exec_valid)
    );

    hdd_sector_buffer u_hdd_sector_buffer (
        .CLK_14M   (CLK_14M),
        .RESET     (RESET),
        .buf_ctl   (buf_ctl),
        .ram_addr  (ram_addr),
        .ram_di    (ram_di),
        .ram_we    (ram_we),
        .ram_do    (ram_do),
        .next_data (next_data)
    );

    hdd_read_mux u_hdd_read_mux (
        .CLK_14M    (CLK_14M),
        .RESET      (RESET),
        .access     (access),
        .regs       (regs),
        .status     (status),
        .exec_data  (exec_data),
        .exec_valid (exec_valid),
        .next_data  (next_data),
        .data_out   (data_out)
    );

endmodule

// ==== logic/hdd_read_mux.sv ====
/*
 * Registered CPU read data
 * Returns 0xFF outside an access and for write accesses
 */
module hdd_read_mux (
    input  logic                 CLK_14M,
    input  logic                 RESET,
    input  hdd_pkg::bus_access_t access,
    input  hdd_pkg::hdd_regs_t   regs,
    input  logic [7:0]           status,
    input  logic [7:0]           exec_data,
    input  logic                 exec_valid,
    input  logic [7:0]           next_data,
    output logic [7:0]           data_out
);

    logic [7:0] rd_sel;

    // Register select for plain reads
    always_comb begin
        if (exec_valid) begin
            rd_sel = exec_data;
        end else begin
            case (access.reg_id)
                hdd_pkg::reg_status:    rd_sel = status;
                hdd_pkg::reg_command:   rd_sel = regs.command;
                hdd_pkg::reg_unit:      rd_sel = regs.unit;
                hdd_pkg::reg_mem_lo:    rd_sel = regs.mem_lo;
                hdd_pkg::reg_mem_hi:    rd_sel = regs.mem_hi;
                hdd_pkg::reg_blk_lo:    rd_sel = regs.blk_lo;
                hdd_pkg::reg_blk_hi:    rd_sel = regs.blk_hi;
                hdd_pkg::reg_next_byte: rd_sel = next_data;
                default:                rd_sel = 8'hFF;
            endcase
        end
    end

    // Capture on the access cycle, hold until device_select drops
    always_ff @(posedge CLK_14M) begin
        if (RESET) begin
            data_out <= 8'hFF;
        end else if (!access.active) begin
            data_out <= 8'hFF;
        end else if (access.valid) begin
            data_out <= access.is_read ? rd_sel : 8'hFF;
        end
    end

endmodule

// ==== logic/hdd_sector_buffer.sv ====
/*
 * 512-byte sector buffer shared by host DMA and CPU next-byte port
 * DMA read data lags ram_addr by 2 cycles
 * Host and CPU never write in the same cycle, the handshake keeps them apart
 */
module hdd_sector_buffer (
    input  logic                              CLK_14M,
    input  logic                              RESET,
    input  hdd_pkg::buf_ctl_t                 buf_ctl,
    input  logic [hdd_pkg::sector_addr_w-1:0] ram_addr,
    input  logic [7:0]                        ram_di,
    input  logic                              ram_we,
    output logic [7:0]                        ram_do,
    output logic [7:0]                        next_data
);

    logic [7:0]                        mem [hdd_pkg::sector_bytes];
    logic [hdd_pkg::sector_addr_w-1:0] ptr;
    logic [7:0]                        dma_q;
    logic [7:0]                        cpu_q;
    logic [7:0]                        next_q;
    logic [7:0]                        prefetch_data;
    logic                              prefetch_valid;

    // ------------------------------------------------------------------------
    // Storage, port A on the DMA address and port B on the sector pointer
    // ------------------------------------------------------------------------
    always_ff @(posedge CLK_14M) begin
        if (ram_we) begin
            mem[ram_addr] <= ram_di;
        end
        if (buf_ctl.cpu_we) begin
            mem[ptr] <= buf_ctl.cpu_wdata;
        end
        dma_q <= mem[ram_addr];
        cpu_q <= mem[ptr];
    end

    // Output stages of both ports
    always_ff @(posedge CLK_14M) begin
        ram_do <= dma_q;
        next_q <= cpu_q;
    end

    // Pointer and prefetch state
    always_ff @(posedge CLK_14M) begin
        if (RESET) begin
            ptr            <= '0;
            prefetch_valid <= 1'b0;
        end else if (buf_ctl.ptr_clear) begin
            // New command, any old prefetch is stale
            ptr            <= '0;
            prefetch_valid <= 1'b0;
        end else begin
            if (buf_ctl.ptr_step) begin
                ptr            <= ptr + 1'b1;
                prefetch_valid <= 1'b0;
            end
            if (buf_ctl.arm_prefetch) begin
                prefetch_valid <= 1'b1;
            end
        end
    end

    // Byte 0 straight from the port B register
    always_ff @(posedge CLK_14M) begin
        if (buf_ctl.arm_prefetch) begin
            prefetch_data <= cpu_q;
        end
    end

    assign next_data = prefetch_valid ? prefetch_data : next_q;

endmodule

// ==== logic/hdd_command_engine.sv ====
/*
 * Register file, command FSM and four-phase host handshake
 * Drive select is bit 7 of the unit register, so unit_count above 2 adds nothing
 * Execute while a command is still running returns status and starts nothing
 */
module hdd_command_engine #(
    parameter int unit_count = 2
) (
    input  logic                  CLK_14M,
    input  logic                  RESET,
    input  hdd_pkg::bus_access_t  access,
    input  logic [unit_count-1:0] mounted,
    input  logic [unit_count-1:0] protect,
    input  logic                  host_ack,
    output logic                  host_req,
    output hdd_pkg::host_req_t    host_cmd,
    output hdd_pkg::buf_ctl_t     buf_ctl,
    output hdd_pkg::hdd_regs_t    regs,
    output logic [7:0]            status,
    output logic [7:0]            exec_data,
    output logic                  exec_valid
);

    typedef enum logic [1:0] {
        idle,
        host_wait_ack,
        host_wait_release,
        streaming
    } state_e;

    state_e     state;
    logic [8:0] byte_count;
    logic       unit_sel;
    logic       unit_mounted;
    logic       unit_protect;
    logic       wr_access;
    logic       rd_access;
    logic       next_access;
    logic       cmd_start;
    logic       exec_start;
    logic [7:0] exec_status;

    assign unit_sel     = regs.unit[7];
    assign unit_mounted = mounted[unit_sel];
    assign unit_protect = protect[unit_sel];

    assign wr_access   = access.valid && !access.is_read;
    assign rd_access   = access.valid && access.is_read;
    assign next_access = access.valid && access.reg_id == hdd_pkg::reg_next_byte;
    assign exec_valid  = rd_access && access.reg_id == hdd_pkg::reg_execute;

    // READ or WRITE written to the command register
    assign cmd_start = wr_access && access.reg_id == hdd_pkg::reg_command
                       && (access.wdata == hdd_pkg::cmd_read
                           || access.wdata == hdd_pkg::cmd_write);

    // ------------------------------------------------------------------------
    // Execute result, decided in the access cycle
    // ------------------------------------------------------------------------
    always_comb begin
        exec_data   = status;
        exec_status = status;
        exec_start  = 1'b0;
        if (state == idle) begin
            case (hdd_pkg::hdd_cmd_e'(regs.command))
                hdd_pkg::cmd_status: begin
                    exec_status = unit_mounted ? hdd_pkg::status_ok : hdd_pkg::status_error;
                    exec_data   = exec_status;
                end
                hdd_pkg::cmd_read: begin
                    exec_start  = unit_mounted;
                    exec_status = unit_mounted ? hdd_pkg::status_busy : hdd_pkg::status_error;
                    exec_data   = exec_status;
                end
                hdd_pkg::cmd_write: begin
                    // Protect wins over the mount check
                    exec_start  = unit_mounted && !unit_protect;
                    exec_status = exec_start ? hdd_pkg::status_busy : hdd_pkg::status_error;
                    exec_data   = unit_protect ? hdd_pkg::status_protect : exec_status;
                end
                // FORMAT and unknown codes just report status
                default: ;
            endcase
        end
    end

    // Buffer control, all single cycle pulses
    always_comb begin
        buf_ctl.ptr_clear    = cmd_start;
        buf_ctl.ptr_step     = next_access;
        buf_ctl.cpu_we       = next_access && !access.is_read;
        buf_ctl.cpu_wdata    = access.wdata;
        // Byte 0 is only worth fetching once the host has filled the buffer
        buf_ctl.arm_prefetch = state == host_wait_release && !host_ack
                               && host_cmd.op == hdd_pkg::op_read_block;
    end

    // ------------------------------------------------------------------------
    // Register file and FSM
    // ------------------------------------------------------------------------
    always_ff @(posedge CLK_14M) begin
        if (RESET) begin
            regs       <= '0;
            status     <= hdd_pkg::status_ok;
            state      <= idle;
            host_req   <= 1'b0;
            byte_count <= '0;
        end else begin
            if (wr_access) begin
                case (access.reg_id)
                    hdd_pkg::reg_command: begin
                        regs.command <= access.wdata;
                        status       <= cmd_start ? hdd_pkg::status_busy : hdd_pkg::status_ok;
                    end
                    hdd_pkg::reg_unit:   regs.unit   <= access.wdata;
                    hdd_pkg::reg_mem_lo: regs.mem_lo <= access.wdata;
                    hdd_pkg::reg_mem_hi: regs.mem_hi <= access.wdata;
                    hdd_pkg::reg_blk_lo: regs.blk_lo <= access.wdata;
                    hdd_pkg::reg_blk_hi: regs.blk_hi <= access.wdata;
                    default: ;
                endcase
            end

            // Counter tracks the buffer pointer
            if (cmd_start) begin
                byte_count <= '0;
            end else if (next_access) begin
                byte_count <= byte_count + 9'd1;
            end

            case (state)
                idle: begin
                    if (exec_valid) begin
                        status <= exec_status;
                    end
                    if (exec_valid && exec_start) begin
                        host_req <= 1'b1;
                        state    <= host_wait_ack;
                    end
                end
                host_wait_ack: begin
                    // Transfer done on the host side
                    if (host_ack) begin
                        host_req <= 1'b0;
                        state    <= host_wait_release;
                    end
                end
                host_wait_release: begin
                    if (!host_ack) begin
                        if (host_cmd.op == hdd_pkg::op_write_block) begin
                            status <= hdd_pkg::status_ok;
                            state  <= idle;
                        end else begin
                            state <= streaming;
                        end
                    end
                end
                streaming: begin
                    // Last byte of the sector ends the READ
                    if (next_access && access.is_read && byte_count == 9'd511) begin
                        status <= hdd_pkg::status_ok;
                        state  <= idle;
                    end
                end
                default: state <= idle;
            endcase
        end
    end

    // Request payload, frozen from execute until the next command
    always_ff @(posedge CLK_14M) begin
        if (state == idle && exec_valid && exec_start) begin
            host_cmd.op    <= regs.command == hdd_pkg::cmd_write
                              ? hdd_pkg::op_write_block : hdd_pkg::op_read_block;
            host_cmd.unit  <= unit_sel;
            host_cmd.block <= {regs.blk_hi, regs.blk_lo};
        end
    end

endmodule

// ==== logic/hdd_bus_decode.sv ====
/*
 * CPU access detect for the device window
 * One access per rising edge of device_select, addr and data sampled there
 * Accesses must be at least 4 cycles apart
 */
module hdd_bus_decode (
    input  logic                 CLK_14M,
    input  logic                 RESET,
    input  logic                 device_select,
    input  logic [3:0]           addr,
    input  logic                 rd,
    input  logic [7:0]           data_in,
    output hdd_pkg::bus_access_t access
);

    logic              sel_d;
    logic              sel_rise;
    logic              valid_q;
    logic              active_q;
    hdd_pkg::hdd_reg_e reg_dec;
    hdd_pkg::hdd_reg_e reg_q;
    logic              rd_q;
    logic [7:0]        wdata_q;

    assign sel_rise = device_select && !sel_d;

    // Offset to register, anything past next byte is unused
    always_comb begin
        case (addr)
            4'h0:    reg_dec = hdd_pkg::reg_execute;
            4'h1:    reg_dec = hdd_pkg::reg_status;
            4'h2:    reg_dec = hdd_pkg::reg_command;
            4'h3:    reg_dec = hdd_pkg::reg_unit;
            4'h4:    reg_dec = hdd_pkg::reg_mem_lo;
            4'h5:    reg_dec = hdd_pkg::reg_mem_hi;
            4'h6:    reg_dec = hdd_pkg::reg_blk_lo;
            4'h7:    reg_dec = hdd_pkg::reg_blk_hi;
            4'h8:    reg_dec = hdd_pkg::reg_next_byte;
            default: reg_dec = hdd_pkg::reg_none;
        endcase
    end

    // Edge detect and the access window
    always_ff @(posedge CLK_14M) begin
        if (RESET) begin
            sel_d    <= 1'b0;
            valid_q  <= 1'b0;
            active_q <= 1'b0;
        end else begin
            sel_d    <= device_select;
            valid_q  <= sel_rise;
            active_q <= device_select;
        end
    end

    // Access payload, captured once per rising edge
    always_ff @(posedge CLK_14M) begin
        if (sel_rise) begin
            reg_q   <= reg_dec;
            rd_q    <= rd;
            wdata_q <= data_in;
        end
    end

    always_comb begin
        access.valid   = valid_q;
        access.active  = active_q;
        access.reg_id  = reg_q;
        access.is_read = rd_q;
        access.wdata   = wdata_q;
    end

endmodule

// ==== logic/hdd_pkg.sv ====
/*
 * Shared types and constants of the ProDOS block-device controller
 * Offsets 9 to 15 of the device window decode to reg_none and are ignored
 * The command register keeps any byte, so only the listed codes have meaning
 */
package hdd_pkg;

    // ------------------------------------------------------------------------
    // Sector buffer geometry
    // ------------------------------------------------------------------------
    localparam int sector_addr_w = 9;
    localparam int sector_bytes  = 512;

    // Register offsets inside the slot device window
    typedef enum logic [3:0] {
        reg_execute   = 4'h0,
        reg_status    = 4'h1,
        reg_command   = 4'h2,
        reg_unit      = 4'h3,
        reg_mem_lo    = 4'h4,
        reg_mem_hi    = 4'h5,
        reg_blk_lo    = 4'h6,
        reg_blk_hi    = 4'h7,
        reg_next_byte = 4'h8,
        reg_none      = 4'hF
    } hdd_reg_e;

    // ProDOS command codes
    typedef enum logic [7:0] {
        cmd_status = 8'h00,
        cmd_read   = 8'h01,
        cmd_write  = 8'h02,
        cmd_format = 8'h03
    } hdd_cmd_e;

    // Status register values
    localparam logic [7:0] status_ok      = 8'h00;
    localparam logic [7:0] status_error   = 8'h01;
    localparam logic [7:0] status_busy    = 8'h80;
    // Write protect code, seen only as execute read data
    localparam logic [7:0] status_protect = 8'h2B;

    // ------------------------------------------------------------------------
    // Structs between the stages
    // ------------------------------------------------------------------------
    // One decoded CPU access, valid for a single cycle
    // Active follows device_select so the result stage knows when it ends
    typedef struct packed {
        logic       valid;
        logic       active;
        hdd_reg_e   reg_id;
        logic       is_read;
        logic [7:0] wdata;
    } bus_access_t;

    typedef enum logic {
        op_read_block  = 1'b0,
        op_write_block = 1'b1
    } host_op_e;

    // Request to the host, held stable while req is high
    typedef struct packed {
        host_op_e    op;
        logic        unit;
        logic [15:0] block;
    } host_req_t;

    // Engine commands to the sector buffer
    typedef struct packed {
        logic       ptr_clear;
        logic       ptr_step;
        logic       cpu_we;
        logic [7:0] cpu_wdata;
        logic       arm_prefetch;
    } buf_ctl_t;

    // Register view for CPU reads
    typedef struct packed {
        logic [7:0] command;
        logic [7:0] unit;
        logic [7:0] mem_lo;
        logic [7:0] mem_hi;
        logic [7:0] blk_lo;
        logic [7:0] blk_hi;
    } hdd_regs_t;

endpackage
